/* common/ppu_pkg.sv */
package ppu_pkg;

    // frame geometry, one dot per clk
    localparam int DOTS_PER_LINE    = 341;
    localparam int LINES_PER_FRAME  = 262;
    localparam int SCREEN_WIDTH     = 256;
    localparam int LAST_DOT         = 340;
    localparam int LAST_LINE        = 261;
    localparam int POST_LINE        = 241;  // post-render line
    localparam int LAST_VIS_LINE    = 240;
    localparam int VIS_LAST_DOT     = 255;

    // horizontal phase boundaries
    localparam int SPRITE_FETCH_END = 320;
    localparam int TILE_FETCH_END   = 336;

    // PPUMASK bits
    localparam int MASK_GREY    = 0;
    localparam int MASK_BG_LEFT = 1;
    localparam int MASK_SP_LEFT = 2;
    localparam int MASK_BG_EN   = 3;
    localparam int MASK_SP_EN   = 4;

    // PPUSTATUS bits
    localparam int STAT_VBLANK  = 7;
    localparam int STAT_SPZERO  = 6;

    // PPUCTRL bits
    localparam int CTRL_NMI_EN  = 7;

    // cpu register select
    typedef enum logic [2:0] {
        REG_CTRL    = 3'd0,
        REG_MASK    = 3'd1,
        REG_STATUS  = 3'd2,
        REG_PALADDR = 3'd3,
        REG_PALDATA = 3'd4
    } reg_t;

    // dot phase within a scanline
    typedef enum logic [2:0] {
        SL_PRE_CYC = 3'd0,  // visible dots 0..255
        IDLE_CYC   = 3'd1,
        SP_PRE_CYC = 3'd2,  // sprite fetch window
        TL_PRE_CYC = 3'd3,  // first tiles of next line
        GARB_CYC   = 3'd4
    } hs_state_t;

    // scanline phase within a frame
    typedef enum logic [1:0] {
        PRE_SL    = 2'd0,
        VIS_SL    = 2'd1,
        POST_SL   = 2'd2,
        VBLANK_SL = 2'd3
    } vs_state_t;

endpackage

/* source/dot_counter.sv */
`timescale 1ns/100ps

module dot_counter (
    input  logic       clk,
    input  logic       rst_n,
    output logic [8:0] row,
    output logic [8:0] col
);
    import ppu_pkg::*;

    logic line_end;

    assign line_end = (col == 9'(LAST_DOT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else begin
            col <= line_end ? 9'd0 : col + 9'd1;
            if (line_end) begin
                // next scanline, frame wraps after the last vblank line
                row <= (row == 9'(LAST_LINE)) ? 9'd0 : row + 9'd1;
            end
        end
    end

    // position must stay inside the 341 x 262 raster
    a_raster_bounds: assert property (
        @(posedge clk) disable iff (!rst_n)
        (col < 9'(DOTS_PER_LINE)) && (row < 9'(LINES_PER_FRAME))
    ) else $error("dot counter out of raster: row %0d col %0d", row, col);

endmodule

/* source/scanline_fsm.sv */
`timescale 1ns/100ps

module scanline_fsm (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [8:0] row,
    input  logic [8:0] col,
    output logic       vblank_set,
    output logic       status_clr,
    output logic       buf_wr,
    output logic       buf_swap
);
    import ppu_pkg::*;

    hs_state_t hs_state, hs_next;
    vs_state_t vs_state, vs_next;
    logic      line_end;

    assign line_end = (col == 9'(LAST_DOT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= SL_PRE_CYC;
            vs_state <= PRE_SL;
        end else begin
            hs_state <= hs_next;
            vs_state <= vs_next;
        end
    end

    // dot phase, leaves each phase on its last dot
    always_comb begin
        hs_next = hs_state;
        case (hs_state)
            SL_PRE_CYC: hs_next = (col < 9'(VIS_LAST_DOT)) ? SL_PRE_CYC : IDLE_CYC;
            IDLE_CYC:   hs_next = SP_PRE_CYC;
            SP_PRE_CYC: hs_next = (col < 9'(SPRITE_FETCH_END)) ? SP_PRE_CYC : TL_PRE_CYC;
            TL_PRE_CYC: hs_next = (col < 9'(TILE_FETCH_END)) ? TL_PRE_CYC : GARB_CYC;
            GARB_CYC:   hs_next = (col < 9'(LAST_DOT)) ? GARB_CYC : SL_PRE_CYC;
            default:    hs_next = SL_PRE_CYC;
        endcase
    end

    // line phase, moves on the last dot of the boundary line
    always_comb begin
        vs_next = vs_state;
        case (vs_state)
            PRE_SL: begin
                if (line_end && row == 9'd0)
                    vs_next = VIS_SL;
            end
            VIS_SL: begin
                if (line_end && row == 9'(LAST_VIS_LINE))
                    vs_next = POST_SL;
            end
            POST_SL: begin
                if (line_end && row == 9'(POST_LINE))
                    vs_next = VBLANK_SL;
            end
            VBLANK_SL: begin
                if (line_end && row == 9'(LAST_LINE))
                    vs_next = PRE_SL;
            end
            default: vs_next = PRE_SL;
        endcase
    end

    assign vblank_set = (vs_state == POST_SL) && (col == 9'd0);  // flag up from dot 1
    assign status_clr = (vs_state == PRE_SL) && (col == 9'd0);
    assign buf_wr     = (hs_state == SL_PRE_CYC) && (vs_state == VIS_SL);
    assign buf_swap   = line_end;  // hand the finished line to the display side

    // visible writes only on rows 1..240, ties the state to the counter
    a_wr_rows: assert property (
        @(posedge clk) disable iff (!rst_n)
        buf_wr |-> (row >= 9'd1) && (row <= 9'(LAST_VIS_LINE))
    ) else $error("line buffer write on row %0d", row);

endmodule

/* source/ppu_regs.sv */
`timescale 1ns/100ps

module ppu_regs (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          reg_en,       // one-cycle access strobe
    input  logic          reg_rw,       // 1 write, 0 read
    input  ppu_pkg::reg_t reg_sel,
    input  logic [7:0]    reg_data_in,
    output logic [7:0]    reg_data_out,
    input  logic          vblank_set,
    input  logic          status_clr,
    input  logic          sp_zero_set,
    input  logic [7:0]    pal_cpu_rd_data,
    output logic [7:0]    mask,
    output logic          nmi_vblank,
    output logic [4:0]    pal_cpu_addr,
    output logic          pal_cpu_we,
    output logic [7:0]    pal_cpu_wr_data
);
    import ppu_pkg::*;

    logic [7:0] ctrl;
    logic       flag_vblank;
    logic       flag_spzero;
    logic [4:0] pal_ptr;
    logic [7:0] status_byte;
    logic [7:0] rd_mux;
    logic       wr_strobe;
    logic       rd_strobe;
    logic       pal_access;
    logic       status_rd;

    assign wr_strobe  = reg_en && reg_rw;
    assign rd_strobe  = reg_en && !reg_rw;
    assign pal_access = reg_en && (reg_sel == REG_PALDATA);  // either direction bumps ptr
    assign status_rd  = rd_strobe && (reg_sel == REG_STATUS);

    always_comb begin
        status_byte              = 8'h00;
        status_byte[STAT_VBLANK] = flag_vblank;
        status_byte[STAT_SPZERO] = flag_spzero;
    end

    always_comb begin
        case (reg_sel)
            REG_CTRL:    rd_mux = ctrl;
            REG_MASK:    rd_mux = mask;
            REG_STATUS:  rd_mux = status_byte;
            REG_PALADDR: rd_mux = {3'b000, pal_ptr};
            REG_PALDATA: rd_mux = pal_cpu_rd_data;
            default:     rd_mux = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl         <= 8'h00;
            mask         <= 8'h00;
            pal_ptr      <= 5'd0;
            reg_data_out <= 8'h00;
        end else begin
            if (wr_strobe) begin
                case (reg_sel)
                    REG_CTRL:    ctrl    <= reg_data_in;
                    REG_MASK:    mask    <= reg_data_in;
                    REG_PALADDR: pal_ptr <= reg_data_in[4:0];
                    default: ;
                endcase
            end
            if (pal_access)
                pal_ptr <= pal_ptr + 5'd1;
            if (rd_strobe)
                reg_data_out <= rd_mux;  // held until the next read
        end
    end

    // status flags, a set on the same edge beats any clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_vblank <= 1'b0;
            flag_spzero <= 1'b0;
        end else begin
            if (vblank_set)
                flag_vblank <= 1'b1;
            else if (status_clr || status_rd)
                flag_vblank <= 1'b0;
            if (sp_zero_set)
                flag_spzero <= 1'b1;
            else if (status_clr)
                flag_spzero <= 1'b0;
        end
    end

    assign nmi_vblank      = flag_vblank && ctrl[CTRL_NMI_EN];
    assign pal_cpu_addr    = pal_ptr;
    assign pal_cpu_we      = wr_strobe && (reg_sel == REG_PALDATA);
    assign pal_cpu_wr_data = reg_data_in;

endmodule

/* source/pal_ram.sv */
`timescale 1ns/100ps

module pal_ram (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [4:0] cpu_addr,
    input  logic       cpu_we,
    input  logic [7:0] cpu_wr_data,
    output logic [7:0] cpu_rd_data,
    input  logic [4:0] rd_addr,     // render side
    output logic [7:0] rd_data
);

    logic [7:0] mem [32];

    // sprite backdrop slots 0x10/0x14/0x18/0x1c alias the bg ones
    function automatic logic [4:0] mirror(input logic [4:0] addr);
        if (addr[4] && addr[1:0] == 2'b00)
            return {1'b0, addr[3:0]};
        return addr;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                mem[i] <= 8'h00;
        end else if (cpu_we) begin
            mem[mirror(cpu_addr)] <= cpu_wr_data;
        end
    end

    assign cpu_rd_data = mem[mirror(cpu_addr)];
    assign rd_data     = mem[mirror(rd_addr)];

endmodule

/* compositor/pixel_mux.sv */
`timescale 1ns/100ps

module pixel_mux (
    input  logic [8:0] col,
    input  logic [7:0] mask,
    input  logic [3:0] bg_idx,
    input  logic [3:0] sp_idx,
    input  logic       sp_prio,   // 1 puts sprite behind opaque bg
    input  logic       sp_zero,
    input  logic       vis,
    input  logic [7:0] pal_data,
    output logic [4:0] pal_addr,
    output logic [5:0] pixel,
    output logic       sp_zero_set
);
    import ppu_pkg::*;

    logic       left_col;
    logic [3:0] bg_m;
    logic [3:0] sp_m;
    logic       bg_opaque;
    logic       sp_opaque;
    logic [7:0] color;

    assign left_col = (col < 9'd8);

    // enable and left-column clipping
    assign bg_m = (!mask[MASK_BG_EN] || (left_col && !mask[MASK_BG_LEFT])) ? 4'h0 : bg_idx;
    assign sp_m = (!mask[MASK_SP_EN] || (left_col && !mask[MASK_SP_LEFT])) ? 4'h0 : sp_idx;

    assign bg_opaque = (bg_m[1:0] != 2'b00);
    assign sp_opaque = (sp_m[1:0] != 2'b00);

    always_comb begin
        if (!bg_opaque && !sp_opaque)
            pal_addr = {1'b0, bg_m};           // backdrop
        else if (!bg_opaque)
            pal_addr = {1'b1, sp_m};
        else if (!sp_opaque)
            pal_addr = {1'b0, bg_m};
        else if (!sp_prio)
            pal_addr = {1'b1, sp_m};           // sprite in front
        else
            pal_addr = {1'b0, bg_m};
    end

    // greyscale keeps only the luma column
    assign color = mask[MASK_GREY] ? (pal_data & 8'h30) : pal_data;
    assign pixel = color[5:0];

    // no hit on the last visible dot
    assign sp_zero_set = vis && (col < 9'(VIS_LAST_DOT)) && sp_zero
                         && bg_opaque && sp_opaque;

endmodule

/* line_buffer/line_buffer.sv */
`timescale 1ns/100ps

module line_buffer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       buf_wr,
    input  logic       buf_swap,
    input  logic [5:0] pixel,
    input  logic [7:0] disp_idx,
    output logic [5:0] disp_color
);
    import ppu_pkg::*;

    logic [5:0] wr_buf   [SCREEN_WIDTH];  // line being composed
    logic [5:0] disp_buf [SCREEN_WIDTH];  // line being shown
    logic [7:0] wr_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_idx <= 8'd0;
        else if (buf_wr)
            wr_idx <= wr_idx + 8'd1;  // wraps after 256 dots
    end

    always_ff @(posedge clk) begin
        if (buf_wr)
            wr_buf[wr_idx] <= pixel;
    end

    // whole line moves across on the last dot
    always_ff @(posedge clk) begin
        if (buf_swap) begin
            for (int i = 0; i < SCREEN_WIDTH; i++)
                disp_buf[i] <= wr_buf[i];
        end
    end

    assign disp_color = disp_buf[disp_idx];

    // a visible line must have delivered exactly 256 pixels by the swap
    a_full_line: assert property (
        @(posedge clk) disable iff (!rst_n)
        buf_swap |-> (wr_idx == 8'd0)
    ) else $error("line swap with write index %0d", wr_idx);

endmodule

/* source/ppu_core.sv */
`timescale 1ns/100ps

module ppu_core (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          reg_en,
    input  logic          reg_rw,
    input  ppu_pkg::reg_t reg_sel,
    input  logic [7:0]    reg_data_in,
    output logic [7:0]    reg_data_out,
    input  logic [3:0]    bg_idx,
    input  logic [3:0]    sp_idx,
    input  logic          sp_prio,
    input  logic          sp_zero,
    input  logic [7:0]    disp_idx,
    output logic [5:0]    disp_color,
    output logic          vblank,   // nmi request
    output logic [8:0]    row,
    output logic [8:0]    col
);

    logic       vblank_set;
    logic       status_clr;
    logic       buf_wr;
    logic       buf_swap;
    logic       sp_zero_set;
    logic [7:0] mask;
    logic [4:0] pal_cpu_addr;
    logic       pal_cpu_we;
    logic [7:0] pal_cpu_wr_data;
    logic [7:0] pal_cpu_rd_data;
    logic [4:0] pal_addr;
    logic [7:0] pal_data;
    logic [5:0] pixel;

    dot_counter u_dot (.clk, .rst_n, .row, .col);

    scanline_fsm u_fsm (
        .clk, .rst_n, .row, .col,
        .vblank_set, .status_clr, .buf_wr, .buf_swap
    );

    ppu_regs u_regs (
        .clk, .rst_n, .reg_en, .reg_rw, .reg_sel, .reg_data_in, .reg_data_out,
        .vblank_set, .status_clr, .sp_zero_set, .pal_cpu_rd_data,
        .mask, .nmi_vblank(vblank),
        .pal_cpu_addr, .pal_cpu_we, .pal_cpu_wr_data
    );

    pal_ram u_pal (
        .clk, .rst_n,
        .cpu_addr(pal_cpu_addr), .cpu_we(pal_cpu_we),
        .cpu_wr_data(pal_cpu_wr_data), .cpu_rd_data(pal_cpu_rd_data),
        .rd_addr(pal_addr), .rd_data(pal_data)
    );

    // buf_wr doubles as the visible-dot qualifier
    pixel_mux u_mux (
        .col, .mask, .bg_idx, .sp_idx, .sp_prio, .sp_zero,
        .vis(buf_wr), .pal_data, .pal_addr, .pixel, .sp_zero_set
    );

    line_buffer u_lbuf (
        .clk, .rst_n, .buf_wr, .buf_swap, .pixel, .disp_idx, .disp_color
    );

endmodule

/* testbench/ppu_tb.sv */
`timescale 1ns/100ps

module ppu_tb;
    import ppu_pkg::*;

    localparam int FRAME_CYCLES   = DOTS_PER_LINE * LINES_PER_FRAME;
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES;
    localparam logic [31:0] LCG_SEED = 32'h1cf6_a17c;
    localparam logic [31:0] LCG_MUL  = 32'h8000_0001;
    localparam logic [31:0] LCG_INC  = 32'h9e37_79b9;

    logic       clk;
    logic       rst_n;
    logic       reg_en;
    logic       reg_rw;
    reg_t       reg_sel;
    logic [7:0] reg_data_in;
    logic [7:0] reg_data_out;
    logic [3:0] bg_idx;
    logic [3:0] sp_idx;
    logic       sp_prio;
    logic       sp_zero;
    logic [7:0] disp_idx;
    logic [5:0] disp_color;
    logic       vblank;
    logic [8:0] row;
    logic [8:0] col;

    logic [31:0] lcg_state = LCG_SEED;
    logic [8:0]  dot_row;
    logic [8:0]  dot_col;
    int          cycles;
    int          checks;
    int          errors;
    int          fd;
    int          code;
    int          a;
    int          b;
    int          c;
    string       kind;
    string       rest;

    ppu_core DUT (
        .clk, .rst_n, .reg_en, .reg_rw, .reg_sel, .reg_data_in, .reg_data_out,
        .bg_idx, .sp_idx, .sp_prio, .sp_zero, .disp_idx, .disp_color,
        .vblank, .row, .col
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * LCG_MUL + LCG_INC;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // dot the DUT enters on this edge, tracked apart from the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            dot_row = 9'd0;
            dot_col = 9'd0;
        end else if (dot_col == 9'(LAST_DOT)) begin
            dot_col   = 9'd0;
            dot_row   = (dot_row == 9'(LAST_LINE)) ? 9'd0 : dot_row + 9'd1;
            lcg_state = lcg_next(lcg_state);  // one step per line
        end else begin
            dot_col = dot_col + 9'd1;
        end
        bg_idx  <= dot_col[3:0];
        sp_idx  <= lcg_state[31:28];
        sp_prio <= dot_row[0];
        sp_zero <= (dot_row == 9'd30);
    end

    // raster position reported by the DUT
    always @(negedge clk) begin
        if (rst_n) begin
            checks += 2;
            assert (row == dot_row) else begin
                errors++;
                $display("FAIL time %0t row expected %0d got %0d", $time, dot_row, row);
            end
            assert (col == dot_col) else begin
                errors++;
                $display("FAIL time %0t col expected %0d got %0d", $time, dot_col, col);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, expected dot never reached", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAIL time %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic reg_write(input int sel, input int data);
        @(posedge clk);
        reg_en      <= 1'b1;
        reg_rw      <= 1'b1;
        reg_sel     <= reg_t'(sel[2:0]);
        reg_data_in <= data[7:0];
        @(posedge clk);
        reg_en      <= 1'b0;
        reg_rw      <= 1'b0;
    endtask

    task automatic reg_read_check(input int sel, input int exp);
        @(posedge clk);
        reg_en  <= 1'b1;
        reg_rw  <= 1'b0;
        reg_sel <= reg_t'(sel[2:0]);
        @(posedge clk);
        reg_en  <= 1'b0;
        @(negedge clk);  // read data lands on the strobe edge
        check_value("reg_data_out", reg_data_out, exp[7:0]);
    endtask

    task automatic wait_dot(input int r, input int cc);
        @(negedge clk);
        while (!(row == 9'(r) && col == 9'(cc)))
            @(negedge clk);
    endtask

    // row r sits in the display buffer for all of row r+1
    task automatic line_check(input int r, input int cc, input int exp);
        @(negedge clk);
        while (!(row == 9'(r + 1) && col < 9'd330))
            @(negedge clk);
        @(posedge clk);
        disp_idx <= cc[7:0];
        @(negedge clk);
        check_value("disp_color", 8'(disp_color), exp[7:0]);
    endtask

    initial begin
        rst_n       = 1'b0;
        reg_en      = 1'b0;
        reg_rw      = 1'b0;
        reg_sel     = REG_CTRL;
        reg_data_in = 8'h00;
        bg_idx      = 4'h0;
        sp_idx      = 4'h0;
        sp_prio     = 1'b0;
        sp_zero     = 1'b0;
        disp_idx    = 8'h00;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("testbench/ppu_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/ppu_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", kind);
                if (code != 1)
                    break;
                if (kind[0] == "#") begin
                    void'($fgets(rest, fd));  // column description
                end else if (kind == "W") begin
                    code = $fscanf(fd, "%d %h", a, b);
                    reg_write(a, b);
                end else if (kind == "R") begin
                    code = $fscanf(fd, "%d %h", a, b);
                    reg_read_check(a, b);
                end else if (kind == "L") begin
                    code = $fscanf(fd, "%d %d %h", a, b, c);
                    line_check(a, b, c);
                end else if (kind == "V") begin
                    code = $fscanf(fd, "%d %d %d", a, b, c);
                    wait_dot(b, c);
                    check_value("vblank", 8'(vblank), a[7:0]);
                end else begin
                    $display("unknown record %s in golden file", kind);
                    errors++;
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* testbench/ppu_golden.txt */
# W sel data | R sel expected | L row col expected_color | V expected_vblank row col
# sel 0 ctrl 1 mask 2 status 3 paladdr 4 paldata, data and expected in hex
R 2 00
W 3 00
W 4 0f
W 4 01
W 4 22
W 4 13
W 4 24
W 4 15
W 4 26
W 4 37
W 3 10
W 4 2d
W 4 31
W 4 32
W 4 33
W 4 3a
W 4 35
W 4 36
W 4 27
W 3 00
R 4 2d
R 4 01
R 3 02
W 3 14
R 4 3a
R 4 35
R 3 16
W 0 80
W 1 1e
L 20 0 27
L 20 5 27
L 20 255 27
L 21 4 31
L 21 6 26
L 27 3 13
L 27 4 3a
W 1 19
L 30 3 20
L 30 9 30
L 30 12 30
R 2 40
W 1 08
V 0 241 0
V 1 241 1
V 1 261 340
V 0 0 1
R 2 00
V 1 241 1
R 2 80
R 2 00
V 0 241 40

/* filelist.f */
common/ppu_pkg.sv
source/dot_counter.sv
source/scanline_fsm.sv
source/ppu_regs.sv
source/pal_ram.sv
compositor/pixel_mux.sv
line_buffer/line_buffer.sv
source/ppu_core.sv
testbench/ppu_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := ppu_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
